//--- logic/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ==============================
  // Flash and sample types
  // ==============================
  localparam int addr_w = 23;

  typedef logic [addr_w-1:0] flash_addr_t;
  typedef logic [7:0]        sample_t;
  typedef logic [15:0]       div_t;

  // One flash word; each half carries its sample in the upper byte
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } halves;
  } flash_word_u;

  // ==============================
  // Rates, credits, song length
  // ==============================
  // About 22 kHz from the 50 MHz clock
  localparam div_t default_sample_div = 16'd2272;
  localparam div_t min_sample_div     = 16'd1136;
  localparam div_t max_sample_div     = 16'd4544;
  localparam div_t speed_step         = 16'd64;

  // Word buffer depth in the sequencer
  localparam int fetch_credits      = 2;
  localparam int credit_w           = $clog2(fetch_credits + 1);
  localparam int ptr_w              = $clog2(fetch_credits);
  localparam int default_song_words = 524288;

  // Keyboard commands, upper case ASCII
  localparam sample_t key_start    = 8'h45;
  localparam sample_t key_stop     = 8'h44;
  localparam sample_t key_forward  = 8'h46;
  localparam sample_t key_backward = 8'h42;
  localparam sample_t key_restart  = 8'h52;

endpackage

`default_nettype wire

//--- logic/player_control.sv
`timescale 1ns/100ps
`default_nettype none

module player_control
  import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    reset,
  input  sample_t kbd_ascii,
  input  logic    kbd_valid,
  output logic    playing,
  output logic    reverse,
  output logic    restart
);

  // Stopped and forward out of reset
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      // Restart is a single-cycle pulse
      restart <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          key_start:
            playing <= 1'b1;
          key_stop:
            playing <= 1'b0;
          key_forward:
            reverse <= 1'b0;
          key_backward:
            reverse <= 1'b1;
          // Play state is left alone on restart
          key_restart:
            restart <= 1'b1;
          default:
            restart <= 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/sample_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module sample_tick_gen
  import ipod_pkg::*;
(
  input  logic CLK_50M,
  input  logic reset,
  input  logic playing,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output div_t sample_div,
  output logic sample_tick
);

  div_t faster_div;
  div_t slower_div;
  div_t tick_count;

  // ==============================
  // Divisor with clamping
  // ==============================
  always_comb
  begin
    if (sample_div - speed_step < min_sample_div)
      faster_div = min_sample_div;
    else
      faster_div = sample_div - speed_step;

    if (sample_div + speed_step > max_sample_div)
      slower_div = max_sample_div;
    else
      slower_div = sample_div + speed_step;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      sample_div  <= default_sample_div;
      tick_count  <= default_sample_div - 1'b1;
      sample_tick <= 1'b0;
    end
    else
    begin
      // speed_reset overrides the other two
      if (speed_reset)
        sample_div <= default_sample_div;
      else if (speed_up)
        sample_div <= faster_div;
      else if (speed_down)
        sample_div <= slower_div;

      sample_tick <= 1'b0;
      // Counter freezes while stopped
      if (playing)
      begin
        if (tick_count == '0)
        begin
          tick_count  <= sample_div - 1'b1;
          sample_tick <= 1'b1;
        end
        else
          tick_count <= tick_count - 1'b1;
      end
    end
  end

  assert property (@(posedge CLK_50M) disable iff (reset)
    sample_div >= min_sample_div && sample_div <= max_sample_div);

endmodule

`default_nettype wire

//--- logic/flash_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module flash_fetch
  import ipod_pkg::*;
#(
  parameter int song_words = default_song_words
)
(
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        reverse,
  input  logic        restart,
  input  logic        word_credit,
  input  logic        flash_waitrequest,
  input  flash_word_u flash_readdata,
  input  logic        flash_readdatavalid,
  output logic        flash_read,
  output flash_addr_t flash_address,
  output logic        word_valid,
  output flash_word_u word_data,
  output logic        word_reverse
);

  flash_addr_t         last_addr;
  flash_addr_t         next_addr;
  flash_addr_t         stepped_addr;
  logic [credit_w-1:0] credits;
  logic                pending;
  logic                fetch_reverse;
  logic                issue;
  logic                accept;
  logic                done;

  assign last_addr = flash_addr_t'(song_words - 1);

  // One read in flight at most, and only with a credit in hand
  assign issue  = !flash_read && !pending && (credits != '0);
  assign accept = flash_read && !flash_waitrequest;
  assign done   = pending && flash_readdatavalid;

  // Next address, wrapping at both ends of the song
  always_comb
  begin
    if (reverse)
      stepped_addr = (next_addr == '0) ? last_addr : next_addr - 1'b1;
    else
      stepped_addr = (next_addr == last_addr) ? '0 : next_addr + 1'b1;
  end

  // ==============================
  // Read sequencing and credits
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      next_addr  <= '0;
      credits    <= credit_w'(fetch_credits);
      pending    <= 1'b0;
      flash_read <= 1'b0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= done;
      if (done)
        pending <= 1'b0;
      if (accept)
      begin
        flash_read <= 1'b0;
        pending    <= 1'b1;
      end
      if (issue)
        flash_read <= 1'b1;

      if (restart)
        next_addr <= reverse ? last_addr : '0;
      else if (issue)
        next_addr <= stepped_addr;

      credits <= credits - credit_w'(issue) + credit_w'(word_credit);
    end
  end

  // Address and data registers, direction tag rides along with the word
  always_ff @(posedge CLK_50M)
  begin
    if (issue)
    begin
      flash_address <= next_addr;
      fetch_reverse <= reverse;
    end
    if (done)
    begin
      word_data.raw <= flash_readdata.raw;
      word_reverse  <= fetch_reverse;
    end
  end

  assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

  assert property (@(posedge CLK_50M) disable iff (reset)
    credits <= credit_w'(fetch_credits));

endmodule

`default_nettype wire

//--- logic/sample_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sample_sequencer
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        sample_tick,
  input  logic        word_valid,
  input  flash_word_u word_data,
  input  logic        word_reverse,
  output logic        word_credit,
  output sample_t     audio_sample,
  output logic        sample_strobe
);

  flash_word_u         slot_word [fetch_credits];
  logic                slot_rev [fetch_credits];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [credit_w-1:0] count;
  logic                half_sel;
  logic                have_word;
  logic                send;
  logic                pop;
  logic                use_hi;
  flash_word_u         head_word;
  sample_t             next_sample;

  assign have_word = (count != '0);
  assign send      = sample_tick && have_word;
  // Second half sent, slot is free again
  assign pop       = send && half_sel;

  // Reversed words play high half first
  assign head_word   = slot_word[rd_ptr];
  assign use_hi      = slot_rev[rd_ptr] ^ half_sel;
  assign next_sample = use_hi ? head_word.halves.hi[15:8] : head_word.halves.lo[15:8];

  // Word storage
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
    begin
      slot_word[wr_ptr] <= word_data;
      slot_rev[wr_ptr]  <= word_reverse;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      half_sel      <= 1'b0;
      sample_strobe <= 1'b0;
      word_credit   <= 1'b0;
      audio_sample  <= '0;
    end
    else
    begin
      sample_strobe <= send;
      word_credit   <= pop;
      if (word_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (send)
      begin
        audio_sample <= next_sample;
        half_sel     <= !half_sel;
      end
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + credit_w'(word_valid) - credit_w'(pop);
    end
  end

  // Credits in the fetcher must keep the buffer from overflowing
  assert property (@(posedge CLK_50M) disable iff (reset)
    word_valid |-> count < credit_w'(fetch_credits));

endmodule

`default_nettype wire

//--- logic/ipod_player.sv
`timescale 1ns/100ps
`default_nettype none

module ipod_player
  import ipod_pkg::*;
#(
  parameter int song_words = default_song_words
)
(
  input  logic        CLK_50M,
  input  logic        reset,
  // Keyboard
  input  sample_t     kbd_ascii,
  input  logic        kbd_valid,
  // Speed pulses
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,
  // Flash read port
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_u flash_readdata,
  input  logic        flash_readdatavalid,
  // Audio out
  output sample_t     audio_sample,
  output logic        sample_strobe,
  output div_t        sample_div
);

  logic        playing;
  logic        reverse;
  logic        restart;
  logic        sample_tick;
  logic        word_valid;
  flash_word_u word_data;
  logic        word_reverse;
  logic        word_credit;

  // ==============================
  // Control and timing
  // ==============================
  player_control i_player_control (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .playing   (playing),
    .reverse   (reverse),
    .restart   (restart)
  );

  sample_tick_gen i_sample_tick_gen (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .playing     (playing),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_div  (sample_div),
    .sample_tick (sample_tick)
  );

  // ==============================
  // Data path
  // ==============================
  flash_fetch #(
    .song_words (song_words)
  ) i_flash_fetch (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .reverse             (reverse),
    .restart             (restart),
    .word_credit         (word_credit),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .word_valid          (word_valid),
    .word_data           (word_data),
    .word_reverse        (word_reverse)
  );

  sample_sequencer i_sample_sequencer (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .sample_tick   (sample_tick),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_reverse  (word_reverse),
    .word_credit   (word_credit),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

endmodule

`default_nettype wire

//--- dv/flash_model.sv
`timescale 1ns/100ps
`default_nettype none

module flash_model
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        flash_read,
  input  flash_addr_t flash_address,
  output logic        flash_waitrequest,
  output flash_word_u flash_readdata,
  output logic        flash_readdatavalid
);

  logic [31:0] rand_state;
  int          wait_left;
  int          latency;
  logic        wait_chosen;
  logic        in_flight;
  flash_addr_t read_addr;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Sample 2w in the low half, 2w+1 in the high half
  function automatic flash_word_u word_at(input flash_addr_t addr);
    flash_word_u word;
    int          w;
    w = int'(addr);
    word.raw = {sample_t'(2 * w + 1), 8'h5A, sample_t'(2 * w), 8'h5A};
    return word;
  endfunction

  initial
  begin
    rand_state          = 32'h22bd;
    wait_left           = 0;
    latency             = 0;
    wait_chosen         = 1'b0;
    in_flight           = 1'b0;
    read_addr           = '0;
    flash_waitrequest   = 1'b0;
    flash_readdata.raw  = '0;
    flash_readdatavalid = 1'b0;
  end

  // Outputs change on the falling edge, the DUT samples on the rising edge
  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    if (latency > 0)
    begin
      latency = latency - 1;
      if (latency == 0)
      begin
        flash_readdata      = word_at(read_addr);
        flash_readdatavalid = 1'b1;
        in_flight           = 1'b0;
      end
    end

    if (flash_read && !in_flight)
    begin
      // 0 to 3 wait cycles per read
      if (!wait_chosen)
      begin
        rand_state  = xorshift32(rand_state);
        wait_left   = int'(rand_state[1:0]);
        wait_chosen = 1'b1;
      end
      if (wait_left > 0)
      begin
        flash_waitrequest = 1'b1;
        wait_left         = wait_left - 1;
      end
      else
      begin
        // Accepted on the next rising edge
        flash_waitrequest = 1'b0;
        wait_chosen       = 1'b0;
        in_flight         = 1'b1;
        read_addr         = flash_address;
        rand_state        = xorshift32(rand_state);
        latency           = 1 + int'(rand_state[1:0]);
      end
    end
    else
      flash_waitrequest = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/tb_ipod_player.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ipod_player
  import ipod_pkg::*;
;

  localparam int tb_song_words = 16;
  localparam int sample_mask   = 2 * tb_song_words - 1;
  localparam int n_steps       = 11;

  // Command kinds
  localparam int cmd_none        = 0;
  localparam int cmd_key         = 1;
  localparam int cmd_up          = 2;
  localparam int cmd_down        = 3;
  localparam int cmd_speed_reset = 4;

  // Special first-sample values
  localparam int any_sample      = -1;
  localparam int continue_sample = -2;

  logic        CLK_50M;
  logic        reset;
  sample_t     kbd_ascii;
  logic        kbd_valid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_u flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        sample_strobe;
  div_t        sample_div;

  // ==============================
  // Step table
  // ==============================
  string   step_name [n_steps];
  int      step_cmd [n_steps];
  sample_t step_key [n_steps];
  int      step_repeat [n_steps];
  int      step_strobes [n_steps];
  int      step_settle [n_steps];
  int      step_first [n_steps];
  int      step_delta [n_steps];
  div_t    step_div [n_steps];
  int      step_quiet [n_steps];

  // Strobe monitor state
  sample_t seen_sample [$];
  int      seen_cycle [$];
  int      cycle_count;
  int      strobe_total;
  int      cycle_limit;

  ipod_player #(
    .song_words (tb_song_words)
  ) i_ipod_player (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_strobe       (sample_strobe),
    .sample_div          (sample_div)
  );

  flash_model i_flash_model (
    .CLK_50M             (CLK_50M),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  initial
    CLK_50M = 1'b0;

  always #10 CLK_50M = ~CLK_50M;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
    if (expected !== actual)
      report_failure($sformatf("FAILED %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic check_div(input string name, input div_t expected, input div_t actual);
    if (expected !== actual)
      report_failure($sformatf("FAILED %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic check_spacing(input string name, input int gap, input div_t div);
    if (gap != int'(div))
      report_failure($sformatf("FAILED %s strobe spacing expected %0d actual %0d",
                               name, div, gap));
  endtask

  task automatic set_step(input int idx, input string name, input int cmd, input sample_t key,
                          input int rep, input int strobes, input int settle, input int first,
                          input int delta, input div_t div, input int quiet);
    step_name[idx]    = name;
    step_cmd[idx]     = cmd;
    step_key[idx]     = key;
    step_repeat[idx]  = rep;
    step_strobes[idx] = strobes;
    step_settle[idx]  = settle;
    step_first[idx]   = first;
    step_delta[idx]   = delta;
    step_div[idx]     = div;
    step_quiet[idx]   = quiet;
  endtask

  task automatic fill_table();
    set_step(0, "idle", cmd_none, 8'h00, 0, 0, 0, any_sample, 0, 16'd2272, 3);
    set_step(1, "start", cmd_key, key_start, 1, 40, 0, 0, 1, 16'd2272, 0);
    // Up to 4 strobes still come from forward words
    set_step(2, "backward", cmd_key, key_backward, 1, 24, 4, any_sample, -1, 16'd2272, 0);
    set_step(3, "restart", cmd_key, key_restart, 1, 8, 4, 31, -1, 16'd2272, 0);
    set_step(4, "speed_up_a", cmd_up, 8'h00, 1, 0, 0, continue_sample, -1, 16'd2208, 0);
    set_step(5, "speed_up_b", cmd_up, 8'h00, 1, 0, 0, continue_sample, -1, 16'd2144, 0);
    set_step(6, "speed_up_c", cmd_up, 8'h00, 1, 6, 0, continue_sample, -1, 16'd2080, 0);
    set_step(7, "speed_down_clamp", cmd_down, 8'h00, 40, 4, 0, continue_sample, -1,
             16'd4544, 0);
    set_step(8, "speed_reset", cmd_speed_reset, 8'h00, 1, 4, 0, continue_sample, -1,
             16'd2272, 0);
    set_step(9, "stop", cmd_key, key_stop, 1, 0, 0, any_sample, -1, 16'd2272, 2);
    set_step(10, "resume", cmd_key, key_start, 1, 4, 0, continue_sample, -1, 16'd2272, 0);
  endtask

  // Pulses on consecutive cycles, then all inputs back to idle
  task automatic apply_command(input int idx);
    int n;
    for (n = 0; n < step_repeat[idx]; n++)
    begin
      @(negedge CLK_50M);
      case (step_cmd[idx])
        cmd_key:
        begin
          kbd_ascii = step_key[idx];
          kbd_valid = 1'b1;
        end
        cmd_up:
          speed_up = 1'b1;
        cmd_down:
          speed_down = 1'b1;
        cmd_speed_reset:
          speed_reset = 1'b1;
        default:
          kbd_valid = 1'b0;
      endcase
    end
    @(negedge CLK_50M);
    kbd_valid   = 1'b0;
    kbd_ascii   = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  // ==============================
  // Strobe monitor and timeout
  // ==============================
  always @(negedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (sample_strobe)
    begin
      seen_sample.push_back(audio_sample);
      seen_cycle.push_back(cycle_count);
      strobe_total = strobe_total + 1;
    end
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      report_failure($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
  end

  initial
  begin
    int      idx;
    int      i;
    int      prev;
    int      prev_cycle;
    int      base;
    int      expected;
    int      got_cycle;
    sample_t got;

    cycle_count  = 0;
    strobe_total = 0;
    cycle_limit  = 0;
    reset        = 1'b1;
    kbd_ascii    = '0;
    kbd_valid    = 1'b0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    prev         = 0;
    prev_cycle   = 0;

    fill_table();
    for (idx = 0; idx < n_steps; idx++)
      cycle_limit = cycle_limit + step_strobes[idx] * int'(max_sample_div);
    cycle_limit = cycle_limit + 2000;

    repeat (5) @(negedge CLK_50M);
    reset = 1'b0;

    for (idx = 0; idx < n_steps; idx++)
    begin
      apply_command(idx);
      repeat (2) @(negedge CLK_50M);
      check_div(step_name[idx], step_div[idx], sample_div);

      // No strobe may appear in the quiet window
      if (step_quiet[idx] > 0)
      begin
        @(posedge CLK_50M);
        base = strobe_total;
        repeat (step_quiet[idx] * int'(step_div[idx])) @(posedge CLK_50M);
        if (strobe_total != base)
          report_failure($sformatf("Unexpected sample_strobe during %s", step_name[idx]));
      end

      @(posedge CLK_50M);
      for (i = 0; i < step_strobes[idx]; i++)
      begin
        while (seen_sample.size() == 0)
          @(posedge CLK_50M);
        got       = seen_sample.pop_front();
        got_cycle = seen_cycle.pop_front();
        if (i >= step_settle[idx] &&
            !(i == step_settle[idx] && step_first[idx] == any_sample))
        begin
          if (i == step_settle[idx] && step_first[idx] >= 0)
            expected = step_first[idx];
          else
            expected = (prev + step_delta[idx]) & sample_mask;
          check_sample(step_name[idx], sample_t'(expected), got);
        end
        if (i >= 2)
          check_spacing(step_name[idx], got_cycle - prev_cycle, step_div[idx]);
        prev       = int'(got);
        prev_cycle = got_cycle;
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/ipod_pkg.sv
logic/player_control.sv
logic/sample_tick_gen.sv
logic/flash_fetch.sv
logic/sample_sequencer.sv
logic/ipod_player.sv
dv/flash_model.sv
dv/tb_ipod_player.sv

//--- Makefile
# Verilator build and run for the audio player testbench

VERILATOR ?= verilator
TOP       ?= tb_ipod_player
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

# Pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)
